//--- common/array_pkg.sv
`default_nettype none

package array_pkg;

        localparam int NUM_ROW         = 8;
        localparam int NUM_COL         = 8;
        localparam int DATA_WIDTH      = 8;

        localparam int OPND_DEPTH      = 1024;
        localparam int OPND_ADDR_WIDTH = 10;
        localparam int BANK_ADDR_WIDTH = 10;

        // Skewed block needs one row per diagonal
        localparam int LD_STEPS        = NUM_ROW + NUM_COL - 1;

        localparam int GEMM_CYCLES     = 2 * NUM_ROW + NUM_COL;
        localparam int DRAIN_CYCLES    = NUM_ROW + NUM_COL;
        localparam int PHASE_CNT_WIDTH = $clog2(GEMM_CYCLES);

        typedef enum logic [3:0] {
                CTRL_IDLE   = 4'd0,
                CTRL_STEADY = 4'd1,
                CTRL_DRAIN  = 4'd3
        } ctrl_state_e;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

        localparam int INST_WIDTH      = 16;
        localparam int BUF_ID_WIDTH    = 2;
        localparam int MEM_LOC_WIDTH   = 10;
        // Opcode takes the top bits above buffer id and location
        localparam int OPCODE_WIDTH    = INST_WIDTH - BUF_ID_WIDTH - MEM_LOC_WIDTH;

        localparam int PROG_DEPTH      = 1024;
        localparam int PROG_ADDR_WIDTH = 10;

        typedef enum logic [OPCODE_WIDTH-1:0] {
                OP_END      = 4'b0000,
                OP_LD       = 4'b0010,
                OP_ST       = 4'b0011,
                OP_GEMM     = 4'b0100,
                OP_DRAINSYS = 4'b0101
        } op_e;

        localparam logic [BUF_ID_WIDTH-1:0] BUF_LEFT = 2'd0;
        localparam logic [BUF_ID_WIDTH-1:0] BUF_TOP  = 2'd1;

        // Opcode kept as raw bits so unknown values pass through the queue
        typedef struct packed {
                logic [OPCODE_WIDTH-1:0]  opcode;
                logic [BUF_ID_WIDTH-1:0]  buf_id;
                logic [MEM_LOC_WIDTH-1:0] mem_loc;
        } inst_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+verif
common/isa_pkg.sv
common/array_pkg.sv
logic/inst_fetch.sv
logic/inst_fifo.sv
logic/inst_executor.sv
loader/operand_memory.sv
loader/skew_loader.sv
logic/gemm_sequencer.sv
verif/tb_gemm_sequencer.sv

//--- loader/operand_memory.sv
`timescale 1ns/1ps
`default_nettype none

module operand_memory
        import array_pkg::*;
(
        input  logic                                    clk,
        input  logic                                    i_wr_en,
        input  logic [OPND_ADDR_WIDTH-1:0]              i_wr_addr,
        input  logic [DATA_WIDTH-1:0]                   i_wr_data,
        input  logic [NUM_ROW-1:0][OPND_ADDR_WIDTH-1:0] i_rd_addr,
        output logic [NUM_ROW-1:0][DATA_WIDTH-1:0]      o_rd_data
);

        logic [DATA_WIDTH-1:0] mem [OPND_DEPTH];

        always_ff @(posedge clk)
        begin
                if (i_wr_en)
                        mem[i_wr_addr] <= i_wr_data;
        end

        // One asynchronous read port per lane
        always_comb
        begin
                for (int j = 0; j < NUM_ROW; j++)
                        o_rd_data[j] = mem[i_rd_addr[j]];
        end

endmodule

`default_nettype wire

//--- loader/skew_loader.sv
`timescale 1ns/1ps
`default_nettype none

module skew_loader
        import array_pkg::*;
(
        input  logic                                    clk,
        input  logic                                    rst_n,
        input  logic                                    i_start,
        input  logic                                    i_buf_top,
        input  logic [OPND_ADDR_WIDTH-1:0]              i_base,
        input  logic [NUM_ROW-1:0][DATA_WIDTH-1:0]      i_rd_data,
        output logic [NUM_ROW-1:0][OPND_ADDR_WIDTH-1:0] o_rd_addr,
        output logic                                    o_done,
        output logic                                    o_left_wr_en,
        output logic [BANK_ADDR_WIDTH-1:0]              o_left_wr_addr,
        output logic [NUM_ROW*DATA_WIDTH-1:0]           o_left_wr_data,
        output logic                                    o_top_wr_en,
        output logic [BANK_ADDR_WIDTH-1:0]              o_top_wr_addr,
        output logic [NUM_COL*DATA_WIDTH-1:0]           o_top_wr_data
);

        logic                               active;
        logic                               buf_top_q;
        logic [OPND_ADDR_WIDTH-1:0]         base_q;
        logic [BANK_ADDR_WIDTH-1:0]         step;
        logic [NUM_ROW-1:0]                 lane_ok;
        logic [BANK_ADDR_WIDTH-1:0]         wr_addr;
        logic [NUM_ROW-1:0][DATA_WIDTH-1:0] wr_data;

        // Lane j lags by j steps; outside its eight-row window it is zero
        always_comb
        begin
                for (int j = 0; j < NUM_ROW; j++)
                begin
                        lane_ok[j]   = (int'(step) >= j) && (int'(step) < j + NUM_ROW);
                        o_rd_addr[j] = base_q + OPND_ADDR_WIDTH'((int'(step) - j) * NUM_ROW + j);
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        active       <= 1'b0;
                        buf_top_q    <= 1'b0;
                        base_q       <= '0;
                        step         <= '0;
                        o_done       <= 1'b0;
                        o_left_wr_en <= 1'b0;
                        o_top_wr_en  <= 1'b0;
                        wr_addr      <= '0;
                        wr_data      <= '0;
                end
                else
                begin
                        o_left_wr_en <= active && !buf_top_q;
                        o_top_wr_en  <= active && buf_top_q;
                        o_done       <= active && (step == BANK_ADDR_WIDTH'(LD_STEPS - 1));
                        if (active)
                        begin
                                wr_addr <= step;
                                for (int j = 0; j < NUM_ROW; j++)
                                        wr_data[j] <= lane_ok[j] ? i_rd_data[j] : '0;
                                if (step == BANK_ADDR_WIDTH'(LD_STEPS - 1))
                                        active <= 1'b0;
                                step <= step + 1'b1;
                        end
                        else if (i_start)
                        begin
                                active    <= 1'b1;
                                buf_top_q <= i_buf_top;
                                base_q    <= i_base;
                                step      <= '0;
                        end
                end
        end

        assign o_left_wr_addr = wr_addr;
        assign o_left_wr_data = wr_data;
        assign o_top_wr_addr  = wr_addr;
        assign o_top_wr_data  = wr_data;

        a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
                i_start |-> !active);

endmodule

`default_nettype wire

//--- logic/gemm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module gemm_sequencer
        import isa_pkg::*, array_pkg::*;
(
        input  logic                          clk,
        input  logic                          rst_n,
        input  logic                          i_start,
        input  logic                          i_prog_wr_en,
        input  logic [PROG_ADDR_WIDTH-1:0]    i_prog_wr_addr,
        input  inst_t                         i_prog_wr_data,
        input  logic                          i_opnd_wr_en,
        input  logic [OPND_ADDR_WIDTH-1:0]    i_opnd_wr_addr,
        input  logic [DATA_WIDTH-1:0]         i_opnd_wr_data,
        output logic                          o_busy,
        output logic                          o_done,
        output logic                          o_left_wr_en,
        output logic [BANK_ADDR_WIDTH-1:0]    o_left_wr_addr,
        output logic [NUM_ROW*DATA_WIDTH-1:0] o_left_wr_data,
        output logic                          o_top_wr_en,
        output logic [BANK_ADDR_WIDTH-1:0]    o_top_wr_addr,
        output logic [NUM_COL*DATA_WIDTH-1:0] o_top_wr_data,
        output ctrl_state_e                   o_ctrl_state
);

        logic                                    push;
        inst_t                                   push_data;
        logic                                    full;
        logic                                    empty;
        logic                                    pop;
        inst_t                                   head;
        logic                                    ld_start;
        logic                                    ld_buf_top;
        logic [OPND_ADDR_WIDTH-1:0]              ld_base;
        logic                                    ld_done;
        logic [NUM_ROW-1:0][OPND_ADDR_WIDTH-1:0] rd_addr;
        logic [NUM_ROW-1:0][DATA_WIDTH-1:0]      rd_data;

        inst_fetch u_fetch (
                .clk(clk), .rst_n(rst_n), .i_start(i_start),
                .i_prog_wr_en(i_prog_wr_en), .i_prog_wr_addr(i_prog_wr_addr),
                .i_prog_wr_data(i_prog_wr_data), .i_full(full),
                .o_push(push), .o_push_data(push_data));

        inst_fifo u_fifo (
                .clk(clk), .rst_n(rst_n), .i_push(push), .i_push_data(push_data),
                .i_pop(pop), .o_head(head), .o_full(full), .o_empty(empty));

        inst_executor u_exec (
                .clk(clk), .rst_n(rst_n), .i_start(i_start), .i_head(head),
                .i_empty(empty), .i_ld_done(ld_done), .o_pop(pop),
                .o_ld_start(ld_start), .o_ld_buf_top(ld_buf_top), .o_ld_base(ld_base),
                .o_ctrl_state(o_ctrl_state), .o_busy(o_busy), .o_done(o_done));

        operand_memory u_opnd (
                .clk(clk), .i_wr_en(i_opnd_wr_en), .i_wr_addr(i_opnd_wr_addr),
                .i_wr_data(i_opnd_wr_data), .i_rd_addr(rd_addr), .o_rd_data(rd_data));

        skew_loader u_loader (
                .clk(clk), .rst_n(rst_n), .i_start(ld_start), .i_buf_top(ld_buf_top),
                .i_base(ld_base), .i_rd_data(rd_data), .o_rd_addr(rd_addr),
                .o_done(ld_done),
                .o_left_wr_en(o_left_wr_en), .o_left_wr_addr(o_left_wr_addr),
                .o_left_wr_data(o_left_wr_data),
                .o_top_wr_en(o_top_wr_en), .o_top_wr_addr(o_top_wr_addr),
                .o_top_wr_data(o_top_wr_data));

endmodule

`default_nettype wire

//--- logic/inst_executor.sv
`timescale 1ns/1ps
`default_nettype none

module inst_executor
        import isa_pkg::*, array_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       i_start,
        input  inst_t                      i_head,
        input  logic                       i_empty,
        input  logic                       i_ld_done,
        output logic                       o_pop,
        output logic                       o_ld_start,
        output logic                       o_ld_buf_top,
        output logic [OPND_ADDR_WIDTH-1:0] o_ld_base,
        output ctrl_state_e                o_ctrl_state,
        output logic                       o_busy,
        output logic                       o_done
);

        typedef enum logic [1:0] {S_IDLE, S_WAIT_LD, S_PHASE} exec_state_e;

        exec_state_e                state;
        logic [PHASE_CNT_WIDTH-1:0] phase_cnt;
        logic                       is_ld;

        // LD to a buffer other than left or top is skipped
        assign is_ld = (i_head.opcode == OP_LD) &&
                       (i_head.buf_id == BUF_LEFT || i_head.buf_id == BUF_TOP);

        assign o_pop        = o_busy && (state == S_IDLE) && !i_empty;
        assign o_ld_start   = o_pop && is_ld;
        assign o_ld_buf_top = (i_head.buf_id == BUF_TOP);
        assign o_ld_base    = i_head.mem_loc;

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state        <= S_IDLE;
                        phase_cnt    <= '0;
                        o_ctrl_state <= CTRL_IDLE;
                        o_busy       <= 1'b0;
                        o_done       <= 1'b0;
                end
                else
                begin
                        o_done <= 1'b0;
                        if (i_start && !o_busy)
                                o_busy <= 1'b1;
                        case (state)
                                S_IDLE:
                                begin
                                        if (o_pop)
                                        begin
                                                case (i_head.opcode)
                                                        OP_LD:
                                                        begin
                                                                if (is_ld)
                                                                        state <= S_WAIT_LD;
                                                        end
                                                        OP_GEMM:
                                                        begin
                                                                o_ctrl_state <= CTRL_STEADY;
                                                                phase_cnt    <= PHASE_CNT_WIDTH'(
                                                                        GEMM_CYCLES - 1);
                                                                state        <= S_PHASE;
                                                        end
                                                        OP_DRAINSYS:
                                                        begin
                                                                o_ctrl_state <= CTRL_DRAIN;
                                                                phase_cnt    <= PHASE_CNT_WIDTH'(
                                                                        DRAIN_CYCLES - 1);
                                                                state        <= S_PHASE;
                                                        end
                                                        OP_END:
                                                        begin
                                                                o_busy <= 1'b0;
                                                                o_done <= 1'b1;
                                                        end
                                                        default:
                                                        begin
                                                                state <= S_IDLE;
                                                        end
                                                endcase
                                        end
                                end
                                S_WAIT_LD:
                                begin
                                        if (i_ld_done)
                                                state <= S_IDLE;
                                end
                                S_PHASE:
                                begin
                                        if (phase_cnt == '0)
                                                state <= S_IDLE;
                                        else
                                                phase_cnt <= phase_cnt - 1'b1;
                                end
                                default:
                                begin
                                        state <= S_IDLE;
                                end
                        endcase
                end
        end

        // Loader completion only arrives while a load is outstanding
        a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
                i_ld_done |-> (state == S_WAIT_LD));

endmodule

`default_nettype wire

//--- logic/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch
        import isa_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       i_start,
        input  logic                       i_prog_wr_en,
        input  logic [PROG_ADDR_WIDTH-1:0] i_prog_wr_addr,
        input  inst_t                      i_prog_wr_data,
        input  logic                       i_full,
        output logic                       o_push,
        output inst_t                      o_push_data
);

        inst_t                      prog_mem [PROG_DEPTH];
        logic [PROG_ADDR_WIDTH-1:0] pc;
        logic                       running;

        always_ff @(posedge clk)
        begin
                if (i_prog_wr_en)
                        prog_mem[i_prog_wr_addr] <= i_prog_wr_data;
        end

        assign o_push_data = prog_mem[pc];
        assign o_push      = running && !i_full;

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        pc      <= '0;
                        running <= 1'b0;
                end
                else if (i_start && !running)
                begin
                        pc      <= '0;
                        running <= 1'b1;
                end
                else if (o_push)
                begin
                        // Stop streaming once END is in the queue
                        if (o_push_data.opcode == OP_END)
                                running <= 1'b0;
                        else
                                pc <= pc + 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- logic/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo
        import isa_pkg::*;
#(
        parameter int DEPTH = 4
)(
        input  logic  clk,
        input  logic  rst_n,
        input  logic  i_push,
        input  inst_t i_push_data,
        input  logic  i_pop,
        output inst_t o_head,
        output logic  o_full,
        output logic  o_empty
);

        inst_t                      entries [DEPTH];
        logic [$clog2(DEPTH)-1:0]   wr_ptr;
        logic [$clog2(DEPTH)-1:0]   rd_ptr;
        logic [$clog2(DEPTH+1)-1:0] count;

        assign o_head  = entries[rd_ptr];
        assign o_full  = (count == ($clog2(DEPTH+1))'(DEPTH));
        assign o_empty = (count == '0);

        always_ff @(posedge clk)
        begin
                if (i_push)
                        entries[wr_ptr] <= i_push_data;
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (i_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (i_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        if (i_push && !i_pop)
                                count <= count + 1'b1;
                        else if (i_pop && !i_push)
                                count <= count - 1'b1;
                end
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
                i_push |-> !o_full);
        a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
                i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
        --top-module tb_gemm_sequencer -f list.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$out" | grep -q -F '*** TEST PASSED ***'; then
        exit 0
fi
exit 1

//--- verif/seq_model.svh
`ifndef SEQ_MODEL_SVH
`define SEQ_MODEL_SVH

// Event kinds seen by the output monitor
localparam int EV_STATE = 0;
localparam int EV_LEFT  = 1;
localparam int EV_TOP   = 2;
localparam int EV_DONE  = 3;
localparam int EV_NONE  = 4;

logic [DATA_WIDTH-1:0] opnd_model [OPND_DEPTH];
int                    error_count = 0;

// Expected events in program order
int          exp_kind    [$];
logic [63:0] exp_val     [$];
int          exp_addr    [$];
int          exp_min_gap [$];
bit          exp_exact   [$];

task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                           input string msg);
        if (got !== exp)
        begin
                error_count++;
                $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
                $display("*** TEST FAILED ***");
                $fatal(1, "value check failed");
        end
endtask

// Lane j of a skewed row lags by j steps and is zero outside its window
function automatic logic [63:0] skew_row(input int base, input int m);
        logic [63:0] row;
        int          k;
        int          addr;
        row = '0;
        for (int j = 0; j < NUM_ROW; j++)
        begin
                k = m - j;
                addr = (base + k * NUM_ROW + j) % OPND_DEPTH;
                if (k >= 0 && k < NUM_ROW)
                        row[j*DATA_WIDTH +: DATA_WIDTH] = opnd_model[addr];
        end
        return row;
endfunction

task automatic add_event(input int kind, input logic [63:0] val, input int addr,
                         input int gap, input bit exact);
        exp_kind.push_back(kind);
        exp_val.push_back(val);
        exp_addr.push_back(addr);
        exp_min_gap.push_back(gap);
        exp_exact.push_back(exact);
endtask

// Repeated phase of the same kind shows no state change, only a longer gap
task automatic enter_phase(inout ctrl_state_e cur, inout int pending,
                           input ctrl_state_e next, input int cycles);
        if (cur != next)
        begin
                add_event(EV_STATE, next, 0, pending, 1'b0);
                cur     = next;
                pending = cycles;
        end
        else
                pending = pending + cycles;
endtask

task automatic build_model(input int len);
        ctrl_state_e cur;
        int          pending;
        inst_t       inst;
        cur     = CTRL_IDLE;
        pending = 0;
        for (int i = 0; i < len; i++)
        begin
                inst = prog_model[i];
                case (inst.opcode)
                        OP_LD:
                        begin
                                for (int m = 0; m < LD_STEPS; m++)
                                        add_event((inst.buf_id == BUF_TOP) ? EV_TOP : EV_LEFT,
                                                  skew_row(int'(inst.mem_loc), m), m,
                                                  (m == 0) ? pending : 1, m != 0);
                                pending = 1;
                        end
                        OP_GEMM:
                                enter_phase(cur, pending, CTRL_STEADY, GEMM_CYCLES);
                        OP_DRAINSYS:
                                enter_phase(cur, pending, CTRL_DRAIN, DRAIN_CYCLES);
                        OP_END:
                                add_event(EV_DONE, '0, 0, pending, 1'b0);
                        default:
                                pending = pending;
                endcase
        end
endtask

`endif

//--- verif/tb_gemm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gemm_sequencer
        import isa_pkg::*, array_pkg::*;
();

        localparam int CLK_PERIOD = 4;
        // Twelve operations, one unknown opcode and END
        localparam int PROG_LEN   = 14;
        localparam int WDOG_CYCLES = 16 + OPND_DEPTH + PROG_LEN + 40 * PROG_LEN + 200;

        logic                          clk;
        logic                          rst_n;
        logic                          i_start;
        logic                          i_prog_wr_en;
        logic [PROG_ADDR_WIDTH-1:0]    i_prog_wr_addr;
        inst_t                         i_prog_wr_data;
        logic                          i_opnd_wr_en;
        logic [OPND_ADDR_WIDTH-1:0]    i_opnd_wr_addr;
        logic [DATA_WIDTH-1:0]         i_opnd_wr_data;
        logic                          o_busy;
        logic                          o_done;
        logic                          o_left_wr_en;
        logic [BANK_ADDR_WIDTH-1:0]    o_left_wr_addr;
        logic [NUM_ROW*DATA_WIDTH-1:0] o_left_wr_data;
        logic                          o_top_wr_en;
        logic [BANK_ADDR_WIDTH-1:0]    o_top_wr_addr;
        logic [NUM_COL*DATA_WIDTH-1:0] o_top_wr_data;
        ctrl_state_e                   o_ctrl_state;

        integer      seed;
        inst_t       prog_model [PROG_LEN];
        int          cyc = 0;
        int          last_evt_cyc = 0;
        int          done_count = 0;
        ctrl_state_e last_state = CTRL_IDLE;

        `include "seq_model.svh"

        gemm_sequencer dut (.*);

        always #(CLK_PERIOD / 2) clk = ~clk;

        task automatic expect_event(input int kind, input logic [63:0] val, input int addr);
                int gap;
                int exp_k;
                gap          = cyc - last_evt_cyc;
                last_evt_cyc = cyc;
                exp_k = (exp_kind.size() > 0) ? exp_kind[0] : EV_NONE;
                check_value(kind, exp_k, "event kind");
                check_value(val, exp_val[0], "event value");
                check_value(addr, exp_addr[0], "buffer write address");
                if (exp_exact[0])
                        check_value(gap, 1, "load rows not in consecutive cycles");
                else
                        check_value(gap >= exp_min_gap[0], 1, "event came too early");
                void'(exp_kind.pop_front());
                void'(exp_val.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_min_gap.pop_front());
                void'(exp_exact.pop_front());
        endtask

        // Outputs sampled mid-cycle, away from the active edge
        always @(negedge clk)
        begin
                if (rst_n)
                begin
                        cyc = cyc + 1;
                        if (o_ctrl_state != last_state)
                        begin
                                expect_event(EV_STATE, o_ctrl_state, 0);
                                last_state = o_ctrl_state;
                        end
                        if (o_left_wr_en)
                                expect_event(EV_LEFT, o_left_wr_data, int'(o_left_wr_addr));
                        if (o_top_wr_en)
                                expect_event(EV_TOP, o_top_wr_data, int'(o_top_wr_addr));
                        if (o_done)
                        begin
                                done_count++;
                                check_value(o_busy, 1'b0, "busy still high with done");
                                expect_event(EV_DONE, '0, 0);
                        end
                end
        end

        task automatic load_operands();
                logic [31:0] r;
                for (int i = 0; i < OPND_DEPTH; i++)
                begin
                        r = $random(seed);
                        opnd_model[i] = r[DATA_WIDTH-1:0];
                        @(posedge clk);
                        i_opnd_wr_en   <= 1'b1;
                        i_opnd_wr_addr <= OPND_ADDR_WIDTH'(i);
                        i_opnd_wr_data <= r[DATA_WIDTH-1:0];
                end
                @(posedge clk);
                i_opnd_wr_en <= 1'b0;
        endtask

        task automatic load_program();
                logic [31:0] r;
                int          unk_pos;
                inst_t       inst;
                r       = $random(seed);
                unk_pos = int'(r % (PROG_LEN - 1));
                for (int i = 0; i < PROG_LEN; i++)
                begin
                        r            = $random(seed);
                        inst.buf_id  = {1'b0, r[10]};
                        inst.mem_loc = r[MEM_LOC_WIDTH-1:0];
                        if (i == PROG_LEN - 1)
                                inst = '0;
                        else if (i == unk_pos)
                                inst.opcode = OPCODE_WIDTH'(6 + r[31:16] % 10);
                        else if (r[31:16] % 3 == 0)
                                inst.opcode = OP_LD;
                        else if (r[31:16] % 3 == 1)
                                inst.opcode = OP_GEMM;
                        else
                                inst.opcode = OP_DRAINSYS;
                        prog_model[i] = inst;
                        @(posedge clk);
                        i_prog_wr_en   <= 1'b1;
                        i_prog_wr_addr <= PROG_ADDR_WIDTH'(i);
                        i_prog_wr_data <= inst;
                end
                @(posedge clk);
                i_prog_wr_en <= 1'b0;
        endtask

        initial
        begin
                seed           = 809;
                clk            = 1'b0;
                rst_n          = 1'b0;
                i_start        = 1'b0;
                i_prog_wr_en   = 1'b0;
                i_prog_wr_addr = '0;
                i_prog_wr_data = '0;
                i_opnd_wr_en   = 1'b0;
                i_opnd_wr_addr = '0;
                i_opnd_wr_data = '0;
                repeat (16) @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                check_value(o_busy, 1'b0, "busy after reset");
                check_value(o_done, 1'b0, "done after reset");
                check_value({o_left_wr_en, o_top_wr_en}, 2'b00, "write enables after reset");
                check_value(o_left_wr_addr | o_top_wr_addr, '0, "write addresses after reset");
                check_value(o_left_wr_data | o_top_wr_data, '0, "write data after reset");
                check_value(o_ctrl_state, CTRL_IDLE, "array state after reset");
                load_operands();
                load_program();
                build_model(PROG_LEN);
                @(posedge clk);
                i_start <= 1'b1;
                @(posedge clk);
                i_start <= 1'b0;
                @(negedge clk);
                check_value(o_busy, 1'b1, "busy after start");
                wait (done_count > 0);
                repeat (10) @(posedge clk);
                check_value(done_count, 1, "number of done pulses");
                check_value(o_busy, 1'b0, "busy after done");
                check_value(exp_kind.size(), 0, "expected events left over");
                if (error_count == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

        initial
        begin
                #(WDOG_CYCLES * CLK_PERIOD);
                $display("timeout: program did not finish within %0d cycles", WDOG_CYCLES);
                $display("*** TEST FAILED ***");
                $fatal(1, "watchdog expired");
        end

endmodule

`default_nettype wire
